//--- bench/lf_alu_vectors.txt
0 0000001 0000002 0 0000003 0 1 0
0 fffffff 0000001 0 0000000 a 1 0
1 fffffff 0000000 1 0000000 a 1 0
1 1234567 0abcdef 1 1cf1357 0 1 0
1 1234567 0abcdef 0 1cf1356 0 1 0
0 0ffffff 0000001 0 1000000 0 1 0
0 0000000 0000000 0 0000000 8 1 0
0 5555555 aaaaaaa 0 fffffff 4 1 0
1 5555555 aaaaaaa 1 0000000 a 1 0
0 7ffffff 0000001 0 8000000 5 1 0
0 4000000 4000000 0 8000000 5 1 0
0 8000000 8000000 0 0000000 b 1 0
0 8000001 fffffff 0 8000000 6 1 0
2 0000005 0000003 0 0000002 2 1 0
2 0000003 0000005 0 ffffffe 4 1 0
2 1234567 1234567 0 0000000 a 1 0
2 8000000 0000001 0 7ffffff 3 1 0
2 0000000 0000001 0 fffffff 4 1 0
2 7ffffff fffffff 0 8000000 5 1 0
2 0000000 8000000 0 8000000 5 1 0
3 0000005 0000003 1 0000002 2 1 0
3 0000005 0000003 0 0000001 2 1 0
3 0000003 0000003 0 fffffff 4 1 0
3 0000003 0000003 1 0000000 a 1 0
4 0000009 0000009 0 0000000 a 0 0
4 0000002 0000007 0 ffffffb 4 0 0
4 8000000 0000001 0 7ffffff 3 0 0
5 1234567 7654321 1 0000000 0 0 1
6 fffffff fffffff 0 0000000 0 0 1
7 0000001 0000001 1 0000000 0 0 1

//--- filelist.f
+incdir+include
hdl/lf_alu_pkg.sv
hdl/ling_prefix_adder.sv
hdl/op_decode.sv
hdl/add_execute.sv
hdl/flag_result.sv
hdl/lf_alu.sv
bench/lf_alu_tb.sv

//--- Makefile
TOP := lf_alu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "^RESULT: PASS$$" > /dev/null

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- bench/lf_alu_tb.sv
// Testbench for the add and subtract unit, vector driven with in-order result checks
`default_nettype none

`include "lf_alu_params.svh"

module lf_alu_tb;

	typedef struct packed {
		logic [`LF_OP_BITS-1:0] op;
		logic [`LF_WIDTH-1:0]   a;
		logic [`LF_WIDTH-1:0]   b;
		logic                   carry_in;
		logic [`LF_WIDTH-1:0]   result;
		logic [3:0]             flags;
		logic                   wr_en;
		logic                   illegal;
	} vector_s;

	typedef struct packed {
		logic [`LF_WIDTH-1:0] result;
		logic [3:0]           flags;
		logic                 wr_en;
		logic                 illegal;
		logic [31:0]          due;
	} expect_s;

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid;
	lf_alu_pkg::alu_cmd_s   cmd;
	logic                   out_valid;
	logic [`LF_WIDTH-1:0]   result;
	lf_alu_pkg::alu_flags_s flags;
	logic                   wr_en;
	logic                   illegal;

	vector_s     vecs[$];
	expect_s     exp_q[$];
	logic [31:0] cycle = '0;
	int          mismatches = 0;
	int          failures = 0;
	logic        timed_out = 1'b0;
	integer      seed = 32'he26a_9a5f;

	lf_alu u_lf_alu (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.cmd       (cmd),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags),
		.wr_en     (wr_en),
		.illegal   (illegal)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic report_mismatch(input string field, input logic [31:0] got,
		input logic [31:0] want);
		mismatches++;
		$display("MISMATCH at %0t: %s is %h, expected %h", $time, field, got, want);
	endtask

	task automatic load_vectors();
		integer      fd;
		integer      n;
		vector_s     v;
		logic [31:0] f_op, f_a, f_b, f_cin, f_res, f_flags, f_wr, f_ill;
		fd = $fopen("bench/lf_alu_vectors.txt", "r");
		if (fd == 0) begin
			failures++;
			$display("Could not open the vector file bench/lf_alu_vectors.txt");
			return;
		end
		n = 8;
		while (n == 8) begin
			n = $fscanf(fd, "%h %h %h %h %h %h %h %h\n",
				f_op, f_a, f_b, f_cin, f_res, f_flags, f_wr, f_ill);
			if (n == 8) begin
				v.op       = f_op[`LF_OP_BITS-1:0];
				v.a        = f_a[`LF_WIDTH-1:0];
				v.b        = f_b[`LF_WIDTH-1:0];
				v.carry_in = f_cin[0];
				v.result   = f_res[`LF_WIDTH-1:0];
				v.flags    = f_flags[3:0];
				v.wr_en    = f_wr[0];
				v.illegal  = f_ill[0];
				vecs.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_commands();
		expect_s e;
		int      gap;
		foreach (vecs[i]) begin
			@(negedge clk);
			in_valid     = 1'b1;
			cmd.op       = vecs[i].op;
			cmd.a        = vecs[i].a;
			cmd.b        = vecs[i].b;
			cmd.carry_in = vecs[i].carry_in;
			e.result     = vecs[i].result;
			e.flags      = vecs[i].flags;
			e.wr_en      = vecs[i].wr_en;
			e.illegal    = vecs[i].illegal;
			// Sampled on the next rising edge, seen at the falling edge after depth edges
			e.due        = cycle + `LF_PIPE_DEPTH;
			exp_q.push_back(e);
			gap = {$random(seed)} % 3;
			repeat (gap) begin
				@(negedge clk);
				in_valid = 1'b0;
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic check_results();
		expect_s e;
		int      waited;
		for (int i = 0; i < vecs.size() && !timed_out; i++) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!out_valid && waited < `LF_PIPE_DEPTH + 2);
			if (!out_valid) begin
				failures++;
				timed_out = 1'b1;
				$display("Timeout at %0t: result %0d never arrived", $time, i);
			end else if (exp_q.size() == 0) begin
				failures++;
				$display("A result came out at %0t with no command pending", $time);
			end else begin
				e = exp_q.pop_front();
				assert (result == e.result) else report_mismatch("result", result, e.result);
				assert (flags == e.flags) else report_mismatch("flags", flags, e.flags);
				assert (wr_en == e.wr_en) else report_mismatch("wr_en", wr_en, e.wr_en);
				assert (illegal == e.illegal)
					else report_mismatch("illegal", illegal, e.illegal);
				assert (cycle == e.due) else report_mismatch("result cycle", cycle, e.due);
			end
		end
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		cmd      = '0;
		load_vectors();
		if (vecs.size() == 0) begin
			failures++;
			$display("No vectors were read from the vector file");
		end
		repeat (8) begin
			@(negedge clk);
			assert (!out_valid) else begin
				failures++;
				$display("out_valid went high during reset at %0t", $time);
			end
		end
		rst_n = 1'b1;
		fork
			drive_commands();
			check_results();
		join
		// Every command answered, the output must stay quiet
		repeat (`LF_PIPE_DEPTH + 2) begin
			@(negedge clk);
			assert (!out_valid) else begin
				failures++;
				$display("Extra out_valid after the last result at %0t", $time);
			end
		end
		if (exp_q.size() != 0) begin
			failures += exp_q.size();
			$display("%0d expected results were never produced", exp_q.size());
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/lf_alu.sv
// Top level of the add and subtract unit, decode, execute and result stages
`default_nettype none

`include "lf_alu_params.svh"

module lf_alu (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  lf_alu_pkg::alu_cmd_s   cmd,
	output logic                   out_valid,
	output logic [`LF_WIDTH-1:0]   result,
	output lf_alu_pkg::alu_flags_s flags,
	output logic                   wr_en,
	output logic                   illegal
);

	logic                 dec_valid;
	lf_alu_pkg::exe_ctl_s dec_ctl;
	logic                 exe_valid;
	lf_alu_pkg::exe_res_s exe_res;

	op_decode u_op_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.cmd       (cmd),
		.dec_valid (dec_valid),
		.dec_ctl   (dec_ctl)
	);

	add_execute u_add_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.dec_valid (dec_valid),
		.dec_ctl   (dec_ctl),
		.exe_valid (exe_valid),
		.exe_res   (exe_res)
	);

	flag_result u_flag_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.exe_valid (exe_valid),
		.exe_res   (exe_res),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags),
		.wr_en     (wr_en),
		.illegal   (illegal)
	);

endmodule

`default_nettype wire

//--- hdl/flag_result.sv
// Result stage, zero, negative, carry and overflow flags with registered outputs
`default_nettype none

`include "lf_alu_params.svh"

module flag_result (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   exe_valid,
	input  lf_alu_pkg::exe_res_s   exe_res,
	output logic                   out_valid,
	output logic [`LF_WIDTH-1:0]   result,
	output lf_alu_pkg::alu_flags_s flags,
	output logic                   wr_en,
	output logic                   illegal
);

	logic                   sum_msb;
	logic [`LF_WIDTH-1:0]   result_d;
	lf_alu_pkg::alu_flags_s flags_d;

	assign sum_msb = exe_res.sum[`LF_WIDTH-1];

	always_comb begin
		result_d         = exe_res.sum;
		flags_d.zero     = (exe_res.sum == '0);
		flags_d.negative = sum_msb;
		// For subtraction this reads as no borrow
		flags_d.carry    = exe_res.cout;
		flags_d.overflow = (exe_res.a_msb == exe_res.b_eff_msb) && (sum_msb != exe_res.a_msb);
		if (exe_res.illegal) begin
			result_d = '0;
			flags_d  = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			wr_en     <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			out_valid <= exe_valid;
			wr_en     <= exe_valid & exe_res.wr_en;
			illegal   <= exe_valid & exe_res.illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (exe_valid) begin
			result <= result_d;
			flags  <= flags_d;
		end
	end

	// Decode never marks an illegal op as writing
	a_wr_illegal_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_en && illegal))
		else $error("wr_en and illegal high together");

endmodule

`default_nettype wire

//--- hdl/add_execute.sv
// Execute stage, prefix adder on the decoded operands with registered sum
`default_nettype none

`include "lf_alu_params.svh"

module add_execute (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   dec_valid,
	input  lf_alu_pkg::exe_ctl_s   dec_ctl,
	output logic                   exe_valid,
	output lf_alu_pkg::exe_res_s   exe_res
);

	logic [`LF_WIDTH-1:0] sum;
	logic                 cout;

	ling_prefix_adder u_adder (
		.a    (dec_ctl.a),
		.b    (dec_ctl.b_eff),
		.cin  (dec_ctl.cin),
		.sum  (sum),
		.cout (cout)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= dec_valid;
		end
	end

	// MSBs kept for the overflow check downstream
	always_ff @(posedge clk) begin
		if (dec_valid) begin
			exe_res.sum       <= sum;
			exe_res.cout      <= cout;
			exe_res.a_msb     <= dec_ctl.a[`LF_WIDTH-1];
			exe_res.b_eff_msb <= dec_ctl.b_eff[`LF_WIDTH-1];
			exe_res.wr_en     <= dec_ctl.wr_en;
			exe_res.illegal   <= dec_ctl.illegal;
		end
	end

	// x - x with no borrow in must give zero and carry set
	a_sub_self_zero: assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid && dec_ctl.is_sub && !dec_ctl.illegal && dec_ctl.cin &&
		(dec_ctl.a == ~dec_ctl.b_eff) |=> (exe_res.sum == '0) && exe_res.cout)
		else $error("subtraction of equal operands not zero");

endmodule

`default_nettype wire

//--- hdl/op_decode.sv
// Decode stage, opcode to operand inversion, carry-in select and write enable
`default_nettype none

`include "lf_alu_params.svh"

module op_decode (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  lf_alu_pkg::alu_cmd_s   cmd,
	output logic                   dec_valid,
	output lf_alu_pkg::exe_ctl_s   dec_ctl
);

	lf_alu_pkg::exe_ctl_s ctl_d;

	always_comb begin
		ctl_d.a       = cmd.a;
		ctl_d.b_eff   = cmd.b;
		ctl_d.cin     = 1'b0;
		ctl_d.wr_en   = 1'b1;
		ctl_d.is_sub  = 1'b0;
		ctl_d.illegal = 1'b0;
		case (cmd.op)
			lf_alu_pkg::OP_ADD: ctl_d.cin = 1'b0;
			lf_alu_pkg::OP_ADC: ctl_d.cin = cmd.carry_in;
			lf_alu_pkg::OP_SUB: begin
				ctl_d.b_eff  = ~cmd.b;
				ctl_d.cin    = 1'b1;
				ctl_d.is_sub = 1'b1;
			end
			// carry_in acts as not-borrow
			lf_alu_pkg::OP_SBB: begin
				ctl_d.b_eff  = ~cmd.b;
				ctl_d.cin    = cmd.carry_in;
				ctl_d.is_sub = 1'b1;
			end
			lf_alu_pkg::OP_CMP: begin
				ctl_d.b_eff  = ~cmd.b;
				ctl_d.cin    = 1'b1;
				ctl_d.is_sub = 1'b1;
				ctl_d.wr_en  = 1'b0;
			end
			default: begin
				ctl_d.wr_en   = 1'b0;
				ctl_d.illegal = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			dec_ctl <= ctl_d;
		end
	end

	a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown(cmd.op))
		else $error("opcode unknown while in_valid is high");

endmodule

`default_nettype wire

//--- hdl/ling_prefix_adder.sv
// Combinational 28-bit Ladner-Fischer prefix adder on Ling pseudo-carries
`default_nettype none

`include "lf_alu_params.svh"

module ling_prefix_adder (
	input  logic [`LF_WIDTH-1:0] a,
	input  logic [`LF_WIDTH-1:0] b,
	input  logic                 cin,
	output logic [`LF_WIDTH-1:0] sum,
	output logic                 cout
);

	// Position 0 holds cin, position k+1 holds operand bit k
	logic [`LF_WIDTH:1]   p;
	logic [`LF_WIDTH:0]   g;
	logic [`LF_WIDTH-1:0] d;
	logic [`LF_WIDTH-1:0] h_pre;
	logic [`LF_WIDTH-1:0] c;

	// Group pairs, bit 1 is H and bit 0 is I
	logic [1:0] hi_3_2, hi_5_4, hi_7_6, hi_9_8, hi_11_10, hi_13_12, hi_15_14;
	logic [1:0] hi_17_16, hi_19_18, hi_21_20, hi_23_22, hi_25_24, hi_27_26;
	logic [1:0] hi_7_4, hi_11_8, hi_15_12, hi_19_16, hi_23_20, hi_27_24;
	logic [1:0] hi_13_8, hi_15_8, hi_21_16, hi_23_16, hi_25_16, hi_27_16;

	// Pseudo-carries spanning down to position 0
	logic h_1_0, h_3_0, h_5_0, h_7_0, h_9_0, h_11_0, h_13_0, h_15_0;
	logic h_17_0, h_19_0, h_21_0, h_23_0, h_25_0, h_27_0;
	logic h_2_0, h_4_0, h_6_0, h_8_0, h_10_0, h_12_0, h_14_0, h_16_0;
	logic h_18_0, h_20_0, h_22_0, h_24_0, h_26_0, h_28_0;

	// Two adjacent positions, generate absorbs the lower transmit
	function automatic logic [1:0] rblk(input logic [1:0] gin, input logic [1:0] pin);
		return {gin[1] | gin[0], pin[1] & pin[0]};
	endfunction

	function automatic logic [1:0] blk(input logic [1:0] hi, input logic [1:0] lo);
		return {hi[1] | (hi[0] & lo[1]), hi[0] & lo[0]};
	endfunction

	function automatic logic gry(input logic [1:0] hi, input logic h_lo);
		return hi[1] | (hi[0] & h_lo);
	endfunction

	assign p = a | b;
	assign g = {a & b, cin};
	assign d = a ^ b;

	// Stage 1, spans of 2
	assign h_1_0    = g[1] | g[0];
	assign hi_3_2   = rblk(g[3:2], p[2:1]);
	assign hi_5_4   = rblk(g[5:4], p[4:3]);
	assign hi_7_6   = rblk(g[7:6], p[6:5]);
	assign hi_9_8   = rblk(g[9:8], p[8:7]);
	assign hi_11_10 = rblk(g[11:10], p[10:9]);
	assign hi_13_12 = rblk(g[13:12], p[12:11]);
	assign hi_15_14 = rblk(g[15:14], p[14:13]);
	assign hi_17_16 = rblk(g[17:16], p[16:15]);
	assign hi_19_18 = rblk(g[19:18], p[18:17]);
	assign hi_21_20 = rblk(g[21:20], p[20:19]);
	assign hi_23_22 = rblk(g[23:22], p[22:21]);
	assign hi_25_24 = rblk(g[25:24], p[24:23]);
	assign hi_27_26 = rblk(g[27:26], p[26:25]);

	// Stage 2, spans of 4
	assign h_3_0    = gry(hi_3_2, h_1_0);
	assign hi_7_4   = blk(hi_7_6, hi_5_4);
	assign hi_11_8  = blk(hi_11_10, hi_9_8);
	assign hi_15_12 = blk(hi_15_14, hi_13_12);
	assign hi_19_16 = blk(hi_19_18, hi_17_16);
	assign hi_23_20 = blk(hi_23_22, hi_21_20);
	assign hi_27_24 = blk(hi_27_26, hi_25_24);

	// Stage 3, spans of 8
	assign h_5_0    = gry(hi_5_4, h_3_0);
	assign h_7_0    = gry(hi_7_4, h_3_0);
	assign hi_13_8  = blk(hi_13_12, hi_11_8);
	assign hi_15_8  = blk(hi_15_12, hi_11_8);
	assign hi_21_16 = blk(hi_21_20, hi_19_16);
	assign hi_23_16 = blk(hi_23_20, hi_19_16);

	// Stage 4, spans of 16
	assign h_9_0    = gry(hi_9_8, h_7_0);
	assign h_11_0   = gry(hi_11_8, h_7_0);
	assign h_13_0   = gry(hi_13_8, h_7_0);
	assign h_15_0   = gry(hi_15_8, h_7_0);
	assign hi_25_16 = blk(hi_25_24, hi_23_16);
	assign hi_27_16 = blk(hi_27_24, hi_23_16);

	// Stage 5, upper half joins the lower 16
	assign h_17_0 = gry(hi_17_16, h_15_0);
	assign h_19_0 = gry(hi_19_16, h_15_0);
	assign h_21_0 = gry(hi_21_16, h_15_0);
	assign h_23_0 = gry(hi_23_16, h_15_0);
	assign h_25_0 = gry(hi_25_16, h_15_0);
	assign h_27_0 = gry(hi_27_16, h_15_0);

	// Even positions from their odd neighbour
	assign h_2_0  = gry({g[2], p[1]}, h_1_0);
	assign h_4_0  = gry({g[4], p[3]}, h_3_0);
	assign h_6_0  = gry({g[6], p[5]}, h_5_0);
	assign h_8_0  = gry({g[8], p[7]}, h_7_0);
	assign h_10_0 = gry({g[10], p[9]}, h_9_0);
	assign h_12_0 = gry({g[12], p[11]}, h_11_0);
	assign h_14_0 = gry({g[14], p[13]}, h_13_0);
	assign h_16_0 = gry({g[16], p[15]}, h_15_0);
	assign h_18_0 = gry({g[18], p[17]}, h_17_0);
	assign h_20_0 = gry({g[20], p[19]}, h_19_0);
	assign h_22_0 = gry({g[22], p[21]}, h_21_0);
	assign h_24_0 = gry({g[24], p[23]}, h_23_0);
	assign h_26_0 = gry({g[26], p[25]}, h_25_0);
	assign h_28_0 = gry({g[28], p[27]}, h_27_0);

	// True carry into bit k is t_k & H_k, transmit of position 0 is 1
	assign h_pre = {h_27_0, h_26_0, h_25_0, h_24_0, h_23_0, h_22_0, h_21_0,
	                h_20_0, h_19_0, h_18_0, h_17_0, h_16_0, h_15_0, h_14_0,
	                h_13_0, h_12_0, h_11_0, h_10_0, h_9_0, h_8_0, h_7_0,
	                h_6_0, h_5_0, h_4_0, h_3_0, h_2_0, h_1_0, g[0]};
	assign c     = {p[`LF_WIDTH-1:1], 1'b1} & h_pre;
	assign sum   = d ^ c;
	assign cout  = p[`LF_WIDTH] & h_28_0;

endmodule

`default_nettype wire

//--- hdl/lf_alu_pkg.sv
// Opcode enum, command, stage and flag structs for the add and subtract unit
`default_nettype none

`include "lf_alu_params.svh"

package lf_alu_pkg;

	// Codes 5 to 7 are illegal
	typedef enum logic [`LF_OP_BITS-1:0] {
		OP_ADD = 3'd0,
		OP_ADC = 3'd1,
		OP_SUB = 3'd2,
		OP_SBB = 3'd3,
		OP_CMP = 3'd4
	} alu_op_e;

	// Raw op field so illegal codes can reach the decoder
	typedef struct packed {
		logic [`LF_OP_BITS-1:0] op;
		logic [`LF_WIDTH-1:0]   a;
		logic [`LF_WIDTH-1:0]   b;
		logic                   carry_in;
	} alu_cmd_s;

	typedef struct packed {
		logic [`LF_WIDTH-1:0] a;
		logic [`LF_WIDTH-1:0] b_eff;
		logic                 cin;
		logic                 wr_en;
		logic                 is_sub;
		logic                 illegal;
	} exe_ctl_s;

	typedef struct packed {
		logic [`LF_WIDTH-1:0] sum;
		logic                 cout;
		logic                 a_msb;
		logic                 b_eff_msb;
		logic                 wr_en;
		logic                 illegal;
	} exe_res_s;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
		logic overflow;
	} alu_flags_s;

endpackage

`default_nettype wire

//--- include/lf_alu_params.svh
// Operand width, opcode width and pipeline depth for the add and subtract unit

`ifndef LF_ALU_PARAMS_SVH
`define LF_ALU_PARAMS_SVH

// Operand and sum width
// The prefix tree in the adder is built for exactly this width
`define LF_WIDTH 28

// Opcode field width
`define LF_OP_BITS 3

// Clock edges from command sample to result
`define LF_PIPE_DEPTH 3

`endif
